// File: common/ooo_pkg.sv
// Shared widths, depths, enums and packed structs of the out-of-order core
package ooo_pkg;

    ////////////////////////////////////////////////////////////
    // Sizes
    ////////////////////////////////////////////////////////////

    localparam int DATA_WIDTH    = 16;
    localparam int NUM_REGS      = 8;
    localparam int ROB_DEPTH     = 8;
    localparam int RS_DEPTH      = 4;
    localparam int REG_IDX_WIDTH = $clog2(NUM_REGS);
    localparam int TAG_WIDTH     = $clog2(ROB_DEPTH);
    localparam int RS_IDX_WIDTH  = $clog2(RS_DEPTH);
    // One extra bit so a full buffer is countable
    localparam int ROB_CNT_WIDTH = $clog2(ROB_DEPTH + 1);

    typedef logic [DATA_WIDTH-1:0]    word_t;
    typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;
    typedef logic [TAG_WIDTH-1:0]     rob_tag_t;

    ////////////////////////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_OR   = 3'd3,
        OP_XOR  = 3'd4,
        OP_ADDI = 3'd5
    } opcode_t;

    // Life of one reorder buffer slot
    typedef enum logic [1:0] {
        ROB_EMPTY   = 2'd0,
        ROB_WAITING = 2'd1,
        ROB_DONE    = 2'd2
    } rob_state_t;

    ////////////////////////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////////////////////////

    // Decoded instruction, 28 bits
    typedef struct packed {
        opcode_t  op;
        reg_idx_t dest;
        reg_idx_t src1;
        reg_idx_t src2;
        word_t    imm;
    } inst_t;

    // Source operand, value valid only when ready, 20 bits
    typedef struct packed {
        logic     ready;
        rob_tag_t tag;
        word_t    value;
    } operand_t;

    // Station to ALU, 39 bits
    typedef struct packed {
        logic     valid;
        opcode_t  op;
        word_t    a;
        word_t    b;
        rob_tag_t tag;
    } issue_t;

    // Common data bus broadcast, 20 bits
    typedef struct packed {
        logic     valid;
        rob_tag_t tag;
        word_t    value;
    } cdb_t;

    // Retirement record, 19 bits
    typedef struct packed {
        reg_idx_t dest;
        word_t    value;
    } commit_t;

endpackage

// File: src/alu_unit.sv
// Single-cycle ALU with registered common data bus output
`timescale 1ns/1ps

module alu_unit (
    input  logic            clock,
    input  logic            reset,
    input  ooo_pkg::issue_t issue,
    output ooo_pkg::cdb_t   cdb
);
    import ooo_pkg::*;

    word_t result;

    // All results wrap at the data width
    always_comb begin
        case (issue.op)
            OP_ADD:  result = issue.a + issue.b;
            OP_SUB:  result = issue.a - issue.b;
            OP_AND:  result = issue.a & issue.b;
            OP_OR:   result = issue.a | issue.b;
            OP_XOR:  result = issue.a ^ issue.b;
            // Operand B already holds the immediate
            OP_ADDI: result = issue.a + issue.b;
            default: result = '0;
        endcase
    end

    // Broadcast one cycle after issue
    always_ff @(posedge clock) begin
        if (reset) begin
            cdb.valid <= 1'b0;
        end else begin
            cdb.valid <= issue.valid;
        end
        cdb.tag   <= issue.tag;
        cdb.value <= result;
    end

endmodule

// File: src/register_map.sv
// Rename table and committed register file with dispatch operand lookup
`timescale 1ns/1ps

module register_map (
    input  logic              clock,
    input  logic              reset,
    input  logic              dispatch,
    input  ooo_pkg::inst_t    dispatch_inst,
    input  ooo_pkg::rob_tag_t dispatch_tag,
    output ooo_pkg::operand_t src1,
    output ooo_pkg::operand_t src2,
    input  logic              retire_valid,
    input  ooo_pkg::rob_tag_t retire_tag,
    input  ooo_pkg::commit_t  retire
);
    import ooo_pkg::*;

    // Per register pending writer flag, its tag and committed value
    logic [NUM_REGS-1:0] pending;
    rob_tag_t            pend_tag [NUM_REGS];
    word_t               arch_val [NUM_REGS];

    // Pending register gives a tag, otherwise the committed value
    function automatic operand_t lookup(input reg_idx_t idx);
        operand_t res;
        res.ready = !pending[idx];
        res.tag   = pend_tag[idx];
        res.value = arch_val[idx];
        return res;
    endfunction

    always_comb begin
        src1 = lookup(dispatch_inst.src1);
        src2 = lookup(dispatch_inst.src2);
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            pending <= '0;
            for (int r = 0; r < NUM_REGS; r++) begin
                arch_val[r] <= '0;
            end
        end else begin
            // Only the newest writer may clear the mapping
            if (retire_valid && pending[retire.dest] &&
                pend_tag[retire.dest] == retire_tag) begin
                pending[retire.dest]  <= 1'b0;
                arch_val[retire.dest] <= retire.value;
            end
            // Rename after retire, so a same-cycle dispatch wins
            if (dispatch) begin
                pending[dispatch_inst.dest]  <= 1'b1;
                pend_tag[dispatch_inst.dest] <= dispatch_tag;
            end
        end
    end

    // Retiring register was renamed at dispatch, either to this tag or a younger one
    a_retire_pending : assert property (
        @(posedge clock) disable iff (reset)
        retire_valid |-> pending[retire.dest]
    ) else $error("retire to register %0d with no pending writer", retire.dest);

endmodule

// File: rob/reorder_buffer.sv
// Circular reorder buffer with tag allocation, result capture, forwarding, in-order retire
`timescale 1ns/1ps

module reorder_buffer (
    input  logic               clock,
    input  logic               reset,
    input  logic               dispatch,
    input  ooo_pkg::reg_idx_t  dispatch_dest,
    output ooo_pkg::rob_tag_t  tail_tag,
    output logic               full,
    input  ooo_pkg::operand_t  look1_in,
    input  ooo_pkg::operand_t  look2_in,
    output ooo_pkg::operand_t  look1_out,
    output ooo_pkg::operand_t  look2_out,
    input  ooo_pkg::cdb_t      cdb,
    output logic               commit_valid,
    output ooo_pkg::commit_t   commit,
    output ooo_pkg::rob_tag_t  retire_tag
);
    import ooo_pkg::*;

    ////////////////////////////////////////////////////////////
    // Storage
    ////////////////////////////////////////////////////////////

    rob_tag_t                 head;
    rob_tag_t                 tail;
    logic [ROB_CNT_WIDTH-1:0] count;
    rob_state_t               state [ROB_DEPTH];
    // Payload per slot
    reg_idx_t                 dest  [ROB_DEPTH];
    word_t                    value [ROB_DEPTH];

    logic retire;

    // Pointers are 3 bits and wrap on their own
    assign tail_tag   = tail;
    assign retire_tag = head;
    assign full       = (count == ROB_CNT_WIDTH'(ROB_DEPTH));

    // Head slot leaves once its result is in
    assign retire       = (state[head] == ROB_DONE);
    assign commit_valid = retire;
    assign commit.dest  = dest[head];
    assign commit.value = value[head];

    ////////////////////////////////////////////////////////////
    // Operand forwarding
    ////////////////////////////////////////////////////////////

    // Finished but unretired results satisfy waiting tags
    function automatic operand_t resolve(input operand_t opnd);
        operand_t res;
        res = opnd;
        if (!opnd.ready && state[opnd.tag] == ROB_DONE) begin
            res.ready = 1'b1;
            res.value = value[opnd.tag];
        end
        return res;
    endfunction

    always_comb begin
        look1_out = resolve(look1_in);
        look2_out = resolve(look2_in);
    end

    ////////////////////////////////////////////////////////////
    // Update
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < ROB_DEPTH; i++) begin
                state[i] <= ROB_EMPTY;
            end
        end else begin
            // Allocate at tail
            if (dispatch) begin
                state[tail] <= ROB_WAITING;
                tail        <= tail + 1'b1;
            end
            // Result capture
            if (cdb.valid) begin
                state[cdb.tag] <= ROB_DONE;
            end
            // Free head slot
            if (retire) begin
                state[head] <= ROB_EMPTY;
                head        <= head + 1'b1;
            end
            count <= count + ROB_CNT_WIDTH'(dispatch) - ROB_CNT_WIDTH'(retire);
        end
    end

    // Payload is meaningful only while the slot is busy
    always_ff @(posedge clock) begin
        if (dispatch) begin
            dest[tail] <= dispatch_dest;
        end
        if (cdb.valid) begin
            value[cdb.tag] <= cdb.value;
        end
    end

    // Top level must hold back dispatch when no slot is left
    a_no_dispatch_full : assert property (
        @(posedge clock) disable iff (reset)
        dispatch |-> !full
    ) else $error("dispatch into a full reorder buffer");

    // Each tag is broadcast once, for a slot still in flight
    a_cdb_waiting : assert property (
        @(posedge clock) disable iff (reset)
        cdb.valid |-> state[cdb.tag] == ROB_WAITING
    ) else $error("broadcast for tag %0d which is not waiting", cdb.tag);

endmodule

// File: rs/reservation_station.sv
// Reservation station entries with bus snooping and lowest-ready issue
`timescale 1ns/1ps

module reservation_station (
    input  logic              clock,
    input  logic              reset,
    input  logic              dispatch,
    input  ooo_pkg::opcode_t  dispatch_op,
    input  ooo_pkg::word_t    dispatch_imm,
    input  ooo_pkg::operand_t src1,
    input  ooo_pkg::operand_t src2,
    input  ooo_pkg::rob_tag_t dispatch_tag,
    input  ooo_pkg::cdb_t     cdb,
    output logic              has_free,
    output ooo_pkg::issue_t   issue
);
    import ooo_pkg::*;

    // Entry state
    logic [RS_DEPTH-1:0] busy;
    opcode_t             op    [RS_DEPTH];
    operand_t            opa   [RS_DEPTH];
    operand_t            opb   [RS_DEPTH];
    rob_tag_t            tag   [RS_DEPTH];

    logic                    issue_hit;
    logic [RS_IDX_WIDTH-1:0] issue_idx;
    logic [RS_IDX_WIDTH-1:0] alloc_idx;
    operand_t                imm_opnd;

    // Take a matching broadcast into a waiting operand
    function automatic operand_t capture(input operand_t opnd, input cdb_t bus);
        operand_t res;
        res = opnd;
        if (!opnd.ready && bus.valid && bus.tag == opnd.tag) begin
            res.ready = 1'b1;
            res.value = bus.value;
        end
        return res;
    endfunction

    // ADDI immediate, always ready
    assign imm_opnd.ready = 1'b1;
    assign imm_opnd.tag   = '0;
    assign imm_opnd.value = dispatch_imm;

    assign has_free = ~&busy;

    ////////////////////////////////////////////////////////////
    // Select
    ////////////////////////////////////////////////////////////

    // Scan downwards so the lowest index wins
    always_comb begin
        issue_hit = 1'b0;
        issue_idx = '0;
        alloc_idx = '0;
        for (int i = RS_DEPTH - 1; i >= 0; i--) begin
            if (busy[i] && opa[i].ready && opb[i].ready) begin
                issue_hit = 1'b1;
                issue_idx = RS_IDX_WIDTH'(i);
            end
            if (!busy[i]) begin
                alloc_idx = RS_IDX_WIDTH'(i);
            end
        end
    end

    always_comb begin
        issue.valid = issue_hit;
        issue.op    = op[issue_idx];
        issue.a     = opa[issue_idx].value;
        issue.b     = opb[issue_idx].value;
        issue.tag   = tag[issue_idx];
    end

    ////////////////////////////////////////////////////////////
    // Update
    ////////////////////////////////////////////////////////////

    // Occupancy; issue frees, dispatch fills a different slot
    always_ff @(posedge clock) begin
        if (reset) begin
            busy <= '0;
        end else begin
            if (issue_hit) begin
                busy[issue_idx] <= 1'b0;
            end
            if (dispatch) begin
                busy[alloc_idx] <= 1'b1;
            end
        end
    end

    // Operand snooping and entry fill
    always_ff @(posedge clock) begin
        for (int i = 0; i < RS_DEPTH; i++) begin
            opa[i] <= capture(opa[i], cdb);
            opb[i] <= capture(opb[i], cdb);
        end
        if (dispatch) begin
            op[alloc_idx]  <= dispatch_op;
            tag[alloc_idx] <= dispatch_tag;
            // Same-cycle broadcast is not yet DONE in the buffer
            opa[alloc_idx] <= capture(src1, cdb);
            if (dispatch_op == OP_ADDI) begin
                opb[alloc_idx] <= imm_opnd;
            end else begin
                opb[alloc_idx] <= capture(src2, cdb);
            end
        end
    end

    // At most one entry leaves per cycle
    a_single_issue : assert property (
        @(posedge clock) disable iff (reset)
        $onehot0($past(busy) & ~busy)
    ) else $error("more than one station entry freed in one cycle");

endmodule

// File: src/ooo_core.sv
// Core top level joining map table, reservation station, ALU and reorder buffer
`timescale 1ns/1ps

module ooo_core (
    input  logic            clock,
    input  logic            reset,
    input  logic            in_valid,
    input  ooo_pkg::inst_t  in_inst,
    output logic            in_ready,
    output logic            commit_valid,
    output ooo_pkg::commit_t commit
);
    import ooo_pkg::*;

    ////////////////////////////////////////////////////////////
    // Interconnect
    ////////////////////////////////////////////////////////////

    logic     dispatch;
    // Operands straight from the map table
    operand_t src1_map;
    operand_t src2_map;
    // Same operands after reorder buffer forwarding
    operand_t src1_fwd;
    operand_t src2_fwd;
    rob_tag_t tail_tag;
    rob_tag_t retire_tag;
    logic     rob_full;
    logic     rs_has_free;
    issue_t   issue;
    cdb_t     cdb;

    // Room needed in both buffer and station
    assign in_ready = !rob_full && rs_has_free;
    assign dispatch = in_valid && in_ready;

    ////////////////////////////////////////////////////////////
    // Blocks
    ////////////////////////////////////////////////////////////

    register_map u_register_map (
        .clock         (clock),
        .reset         (reset),
        .dispatch      (dispatch),
        .dispatch_inst (in_inst),
        .dispatch_tag  (tail_tag),
        .src1          (src1_map),
        .src2          (src2_map),
        .retire_valid  (commit_valid),
        .retire_tag    (retire_tag),
        .retire        (commit)
    );

    reorder_buffer u_reorder_buffer (
        .clock         (clock),
        .reset         (reset),
        .dispatch      (dispatch),
        .dispatch_dest (in_inst.dest),
        .tail_tag      (tail_tag),
        .full          (rob_full),
        .look1_in      (src1_map),
        .look2_in      (src2_map),
        .look1_out     (src1_fwd),
        .look2_out     (src2_fwd),
        .cdb           (cdb),
        .commit_valid  (commit_valid),
        .commit        (commit),
        .retire_tag    (retire_tag)
    );

    reservation_station u_reservation_station (
        .clock        (clock),
        .reset        (reset),
        .dispatch     (dispatch),
        .dispatch_op  (in_inst.op),
        .dispatch_imm (in_inst.imm),
        .src1         (src1_fwd),
        .src2         (src2_fwd),
        .dispatch_tag (tail_tag),
        .cdb          (cdb),
        .has_free     (rs_has_free),
        .issue        (issue)
    );

    alu_unit u_alu_unit (
        .clock (clock),
        .reset (reset),
        .issue (issue),
        .cdb   (cdb)
    );

endmodule

// File: tb/tb_ooo_core.sv
// Testbench for the out-of-order core with file-driven stimulus, commit monitor and timeout
`timescale 1ns/1ps

module tb_ooo_core;
    import ooo_pkg::*;

    logic    clock;
    logic    reset;
    logic    in_valid;
    inst_t   in_inst;
    logic    in_ready;
    logic    commit_valid;
    commit_t commit;

    // Program and expected retirements from the data file
    inst_t   prog_q [$];
    logic    burst_q [$];
    commit_t expect_q [$];

    int   commit_idx  = 0;
    int   cycles      = 0;
    int   cycle_limit = 100;
    logic saw_stall   = 1'b0;

    ooo_core UUT (
        .clock        (clock),
        .reset        (reset),
        .in_valid     (in_valid),
        .in_inst      (in_inst),
        .in_ready     (in_ready),
        .commit_valid (commit_valid),
        .commit       (commit)
    );

    initial begin
        clock = 1'b0;
        forever #10 clock = ~clock;
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("RESULT: FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check_reg(input string name, input reg_idx_t expected, input reg_idx_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("Error at %0d ns: %s expected %0d got %0d",
                                $time, name, expected, actual));
        end
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            abort_run($sformatf("Error at %0d ns: %s expected %h got %h",
                                $time, name, expected, actual));
        end
    endtask

    task automatic check_flag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abort_run($sformatf("Error at %0d ns: %s expected %b got %b",
                                $time, name, expected, actual));
        end
    endtask

    // I records fill the program, C records the expected commits
    task automatic load_stimulus();
        int             fd;
        int             op;
        int             dest;
        int             s1;
        int             s2;
        int             imm;
        int             burst;
        logic [7:0]     kind;
        logic [1023:0]  line;
        inst_t          inst;
        commit_t        rec;
        fd = $fopen("tb/ooo_stim.txt", "r");
        if (fd == 0) begin
            abort_run("Could not open the stimulus file tb/ooo_stim.txt");
        end
        while ($fscanf(fd, "%s", kind) == 1) begin
            if (kind == "#") begin
                void'($fgets(line, fd));
            end else if (kind == "I") begin
                void'($fscanf(fd, "%d %d %d %d %h %d", op, dest, s1, s2, imm, burst));
                inst.op   = opcode_t'(op[2:0]);
                inst.dest = reg_idx_t'(dest);
                inst.src1 = reg_idx_t'(s1);
                inst.src2 = reg_idx_t'(s2);
                inst.imm  = word_t'(imm);
                prog_q.push_back(inst);
                burst_q.push_back(burst != 0);
            end else if (kind == "C") begin
                void'($fscanf(fd, "%d %h", dest, imm));
                rec.dest  = reg_idx_t'(dest);
                rec.value = word_t'(imm);
                expect_q.push_back(rec);
            end else begin
                abort_run("Unrecognized record type in the stimulus file");
            end
        end
        $fclose(fd);
    endtask

    // Held until a falling edge sees room, taken at the rising edge after it
    task automatic send_instruction(input inst_t inst, input logic burst);
        in_valid = 1'b1;
        in_inst  = inst;
        while (!in_ready) begin
            if (burst) begin
                saw_stall = 1'b1;
            end
            @(negedge clock);
        end
        @(negedge clock);
        in_valid = 1'b0;
    endtask

    ////////////////////////////////////////////////////////////
    // Monitor and timeout
    ////////////////////////////////////////////////////////////

    // Commit outputs depend on state only, so the falling edge sees them settled
    always @(negedge clock) begin
        if (!reset && commit_valid) begin
            if (commit_idx >= expect_q.size()) begin
                abort_run("A commit arrived after all expected commits were seen");
            end else begin
                check_reg("commit.dest", expect_q[commit_idx].dest, commit.dest);
                check_word("commit.value", expect_q[commit_idx].value, commit.value);
                commit_idx++;
            end
        end
    end

    always @(posedge clock) begin
        cycles <= cycles + 1;
        if (cycles >= cycle_limit) begin
            abort_run($sformatf("Timeout after %0d cycles", cycles));
        end
    end

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        int gap;
        int drain;
        reset    = 1'b1;
        in_valid = 1'b0;
        in_inst  = '0;
        void'($urandom(32'hdbb74a1c));
        load_stimulus();
        cycle_limit = 20 * prog_q.size() + 100;
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;
        // Idle core accepts and retires nothing
        repeat (3) begin
            check_flag("in_ready", 1'b1, in_ready);
            check_flag("commit_valid", 1'b0, commit_valid);
            @(negedge clock);
        end
        for (int i = 0; i < prog_q.size(); i++) begin
            if (!burst_q[i]) begin
                gap = $urandom % 4;
                repeat (gap) @(negedge clock);
            end
            send_instruction(prog_q[i], burst_q[i]);
        end
        // Drain what is still in flight
        drain = 0;
        while (commit_idx < expect_q.size() && drain < 20 * ROB_DEPTH) begin
            @(negedge clock);
            drain++;
        end
        repeat (4) @(negedge clock);
        if (commit_idx != expect_q.size()) begin
            abort_run($sformatf("Only %0d of %0d expected commits arrived",
                                commit_idx, expect_q.size()));
        end else if (!saw_stall) begin
            abort_run("in_ready never dropped during the back-to-back burst");
        end else begin
            $display("RESULT: PASS");
            $finish;
        end
    end

endmodule

// File: tb/ooo_stim.txt
# I op dest src1 src2 imm(hex) burst : op 0 ADD 1 SUB 2 AND 3 OR 4 XOR 5 ADDI, burst 1 means no idle gap
# C dest value(hex) : expected commits in program order
I 5 1 0 0 1234 0
I 5 2 0 0 f0f0 0
I 1 4 0 1 0000 0
I 2 5 1 2 0000 0
I 3 6 1 2 0000 0
I 4 7 1 2 0000 0
I 0 3 1 2 0000 0
I 0 4 2 2 0000 0
I 5 2 0 0 0100 0
I 0 5 2 4 0000 0
I 5 1 1 0 0001 1
I 0 1 1 1 0000 1
I 1 1 1 6 0000 1
I 4 1 1 7 0000 1
I 2 1 1 5 0000 1
I 3 3 1 3 0000 1
I 5 3 3 0 3c5d 1
I 0 2 3 2 0000 1
I 4 0 2 4 0000 1
I 5 6 0 0 2345 1
C 1 1234
C 2 f0f0
C 4 edcc
C 5 1030
C 6 f2f4
C 7 e2c4
C 3 0324
C 4 e1e0
C 2 0100
C 5 e2e0
C 1 1235
C 1 246a
C 1 3176
C 1 d3b2
C 1 c2a0
C 3 c3a4
C 3 0001
C 2 0101
C 0 e0e1
C 6 0426

// File: ooo_core.f
common/ooo_pkg.sv
src/alu_unit.sv
src/register_map.sv
rob/reorder_buffer.sv
rs/reservation_station.sv
src/ooo_core.sv
tb/tb_ooo_core.sv

// File: run.sh
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module tb_ooo_core -f ooo_core.f
status=0
out=$(./obj_dir/Vtb_ooo_core 2>&1) || status=$?
printf '%s\n' "$out"
if printf '%s\n' "$out" | grep -q "RESULT: PASS"; then
    exit 0
fi
echo "Simulation did not pass, exit status $status"
exit 1
